//--- hdl/rvfi_settings.svh
// --------------------
// Widths, sizes and instruction encodings for the RVFI commit tracer
// Included by the package and by every module that sizes a port or array
// --------------------
`ifndef RVFI_SETTINGS_SVH
`define RVFI_SETTINGS_SVH

`define RVFI_XLEN           64
`define RVFI_NR_SB_ENTRIES  8
`define RVFI_TRANS_ID_BITS  3
`define RVFI_FETCH_WIDTH    2
`define RVFI_BE_WIDTH       8

// System return instructions, full 32-bit words
`define RVFI_INSN_MRET      32'h3020_0073
`define RVFI_INSN_SRET      32'h1020_0073

`define RVFI_OPC_AMO        7'h2f
`define RVFI_FUNCT5_LR      5'h02
`define RVFI_FUNCT5_SC      5'h03

`define RVFI_CAUSE_ECALL_U  8
`define RVFI_CAUSE_ECALL_S  9
`define RVFI_CAUSE_ECALL_M  11
`define RVFI_MODE_DEBUG     2'b10  // Reported mode while in debug

`endif

//--- hdl/rvfi_pkg.sv
// --------------------
// Shared types of the commit tracer
// Pipeline event records in, one RVFI record out
// --------------------
`include "rvfi_settings.svh"

package rvfi_pkg;

  // Field view of an A-extension instruction
  typedef struct packed {
    logic [4:0] funct5;
    logic       aq;
    logic       rl;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } amo_fields_t;

  // Same word, read raw for mret/sret or by fields for lr/sc
  typedef union packed {
    logic [31:0] raw;
    amo_fields_t amo;
  } insn_t;

  typedef struct packed {
    logic  [`RVFI_FETCH_WIDTH-1:0] valid;
    logic  [`RVFI_FETCH_WIDTH-1:0] compressed;
    insn_t [`RVFI_FETCH_WIDTH-1:0] insn;
  } fetch_t;

  typedef struct packed {
    logic                          valid;           // Decoded instruction issued
    logic                          flush_unissued;
    logic [`RVFI_TRANS_ID_BITS-1:0] pointer;
    logic [`RVFI_XLEN-1:0]         rs1_fwd;
    logic [`RVFI_XLEN-1:0]         rs2_fwd;
  } issue_t;

  typedef struct packed {
    logic                          is_load;
    logic                          is_store;
    logic [`RVFI_BE_WIDTH-1:0]     be;
    logic [`RVFI_XLEN-1:0]         vaddr;
    logic [`RVFI_TRANS_ID_BITS-1:0] trans_id;
    logic [`RVFI_XLEN-1:0]         wdata;
  } lsu_t;

  // One side-memory entry per scoreboard slot
  typedef struct packed {
    insn_t                     insn;
    logic [`RVFI_XLEN-1:0]     rs1_rdata;
    logic [`RVFI_XLEN-1:0]     rs2_rdata;
    logic [`RVFI_XLEN-1:0]     lsu_addr;
    logic [`RVFI_BE_WIDTH-1:0] rmask;
    logic [`RVFI_BE_WIDTH-1:0] wmask;
    logic [`RVFI_XLEN-1:0]     wdata;
  } sb_entry_t;

  typedef struct packed {
    logic                          ack;
    logic [`RVFI_TRANS_ID_BITS-1:0] pointer;
    logic [`RVFI_XLEN-1:0]         pc;
    logic [`RVFI_XLEN-1:0]         next_pc;
    logic                          is_ctrl_flow;
    logic [4:0]                    rs1_addr;
    logic [4:0]                    rs2_addr;
    logic [4:0]                    rd_addr;
    logic [`RVFI_XLEN-1:0]         result;
    logic                          ex_valid;
    logic [`RVFI_XLEN-1:0]         ex_cause;
  } commit_t;

  typedef struct packed {
    logic [1:0]            priv_lvl;
    logic                  debug_mode;
    logic [`RVFI_XLEN-1:0] mtvec;
    logic [`RVFI_XLEN-1:0] mepc;
    logic [`RVFI_XLEN-1:0] sepc;
  } hart_state_t;

  typedef struct packed {
    logic                      valid;
    logic [31:0]               insn;
    logic                      trap;
    logic [`RVFI_XLEN-1:0]     cause;
    logic [1:0]                mode;
    logic [4:0]                rs1_addr;
    logic [4:0]                rs2_addr;
    logic [`RVFI_XLEN-1:0]     rs1_rdata;
    logic [`RVFI_XLEN-1:0]     rs2_rdata;
    logic [4:0]                rd_addr;
    logic [`RVFI_XLEN-1:0]     rd_wdata;
    logic [`RVFI_XLEN-1:0]     pc_rdata;
    logic [`RVFI_XLEN-1:0]     pc_wdata;
    logic [`RVFI_XLEN-1:0]     mem_addr;
    logic [`RVFI_BE_WIDTH-1:0] mem_rmask;
    logic [`RVFI_BE_WIDTH-1:0] mem_wmask;
    logic [`RVFI_XLEN-1:0]     mem_rdata;
    logic [`RVFI_XLEN-1:0]     mem_wdata;
  } rvfi_trace_t;

endpackage

//--- hdl/rvfi_issue_buffer.sv
// --------------------
// Two-entry queue between the fetch window and issue
// Head entry is the instruction the core issues next
// --------------------
`include "rvfi_settings.svh"

module rvfi_issue_buffer
  import rvfi_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  fetch_t fetch_i,
  input  logic   issue_ack_i,
  input  logic   flush_i,
  output insn_t  head_insn_o
);

  localparam int unsigned tail_idx = `RVFI_FETCH_WIDTH - 1;

  typedef struct packed {
    logic  valid;
    insn_t insn;
  } slot_t;

  insn_t [`RVFI_FETCH_WIDTH-1:0] trunc;
  slot_t [`RVFI_FETCH_WIDTH-1:0] buf_d, buf_q;
  logic                          took0;

  // Compressed words keep only their low half
  for (genvar i = 0; i < `RVFI_FETCH_WIDTH; i++) begin : gen_trunc
    assign trunc[i].raw = fetch_i.compressed[i] ? {16'h0, fetch_i.insn[i].raw[15:0]}
                                                : fetch_i.insn[i].raw;
  end

  always_comb begin
    buf_d = buf_q;
    took0 = 1'b0;

    if (issue_ack_i) buf_d[0].valid = 1'b0;  // Head consumed by issue

    if (!buf_d[tail_idx].valid) begin
      buf_d[tail_idx].valid = fetch_i.valid[0];
      buf_d[tail_idx].insn  = trunc[0];
      took0 = 1'b1;
    end

    // Advance tail into an empty head
    if (!buf_d[0].valid) begin
      buf_d[0] = buf_d[tail_idx];
      buf_d[tail_idx].valid = 1'b0;
    end

    // Refill tail, slot 1 only after slot 0 is in
    if (!buf_d[tail_idx].valid) begin
      if (took0) begin
        buf_d[tail_idx].valid = fetch_i.valid[tail_idx];
        buf_d[tail_idx].insn  = trunc[tail_idx];
      end else begin
        buf_d[tail_idx].valid = fetch_i.valid[0];
        buf_d[tail_idx].insn  = trunc[0];
      end
    end

    if (flush_i) begin
      for (int unsigned i = 0; i < `RVFI_FETCH_WIDTH; i++) begin
        buf_d[i].valid = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_q <= '0;
    end else begin
      buf_q <= buf_d;
    end
  end

  assign head_insn_o = buf_q[0].insn;

endmodule

//--- hdl/rvfi_sb_store.sv
// --------------------
// Side memory indexed by scoreboard transaction id
// Filled at issue, memory fields patched by load-store reports
// --------------------
`include "rvfi_settings.svh"

module rvfi_sb_store
  import rvfi_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  issue_t                               issue_i,
  input  insn_t                                head_insn_i,
  input  lsu_t                                 lsu_i,
  output sb_entry_t [`RVFI_NR_SB_ENTRIES-1:0] entries_o
);

  sb_entry_t [`RVFI_NR_SB_ENTRIES-1:0] mem_d, mem_q;

  logic                      issue_we;
  insn_t                     lsu_insn;
  logic                      lsu_is_lr;
  logic [`RVFI_BE_WIDTH-1:0] lsu_rmask;
  logic [`RVFI_BE_WIDTH-1:0] lsu_wmask;

  assign issue_we = issue_i.valid && !issue_i.flush_unissued;

  // --------------------
  // Report classification
  // --------------------

  // Instruction of the addressed entry, including one being issued now
  assign lsu_insn = (issue_we && (issue_i.pointer == lsu_i.trans_id)) ? head_insn_i
                                                                      : mem_q[lsu_i.trans_id].insn;

  assign lsu_is_lr = (lsu_insn.amo.opcode == `RVFI_OPC_AMO) &&
                     (lsu_insn.amo.funct5 == `RVFI_FUNCT5_LR);

  // The LSU runs lr through its store path, it still reads memory
  assign lsu_rmask = (lsu_i.is_load || (lsu_i.is_store && lsu_is_lr)) ? lsu_i.be : '0;
  assign lsu_wmask = (lsu_i.is_store && !lsu_is_lr) ? lsu_i.be : '0;

  // --------------------
  // Entry update
  // --------------------

  always_comb begin
    mem_d = mem_q;

    if (issue_we) begin
      mem_d[issue_i.pointer] = '{
        insn:      head_insn_i,
        rs1_rdata: issue_i.rs1_fwd,
        rs2_rdata: issue_i.rs2_fwd,
        lsu_addr:  '0,
        rmask:     '0,
        wmask:     '0,
        wdata:     '0
      };
    end

    // Applied after issue so a same-cycle report wins
    if (lsu_rmask != '0) begin
      mem_d[lsu_i.trans_id].lsu_addr = lsu_i.vaddr;
      mem_d[lsu_i.trans_id].rmask    = lsu_rmask;
    end else if (lsu_wmask != '0) begin
      mem_d[lsu_i.trans_id].lsu_addr = lsu_i.vaddr;
      mem_d[lsu_i.trans_id].wmask    = lsu_wmask;
      mem_d[lsu_i.trans_id].wdata    = lsu_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_d;
    end
  end

  assign entries_o = mem_q;

endmodule

//--- hdl/rvfi_commit_pack.sv
// --------------------
// Builds one RVFI record per retired instruction
// Record appears on trace_o one clock after the commit strobe
// --------------------
`include "rvfi_settings.svh"

module rvfi_commit_pack
  import rvfi_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  commit_t                              commit_i,
  input  sb_entry_t [`RVFI_NR_SB_ENTRIES-1:0] entries_i,
  input  hart_state_t                          state_i,
  output rvfi_trace_t                          trace_o
);

  localparam int unsigned offs_bits = $clog2(`RVFI_BE_WIDTH);

  sb_entry_t   ent;
  logic        exception;
  logic        is_ecall;
  logic        sc_fail;
  logic        is_mret;
  logic        is_sret;
  rvfi_trace_t trace_d, trace_q;

  assign ent = entries_i[commit_i.pointer];  // Side data of the retiring entry

  // --------------------
  // Decode of the commit
  // --------------------

  assign exception = commit_i.ack && commit_i.ex_valid;

  assign is_ecall = (commit_i.ex_cause == `RVFI_XLEN'(`RVFI_CAUSE_ECALL_U)) ||
                    (commit_i.ex_cause == `RVFI_XLEN'(`RVFI_CAUSE_ECALL_S)) ||
                    (commit_i.ex_cause == `RVFI_XLEN'(`RVFI_CAUSE_ECALL_M));

  // sc writes 1 to rd when the reservation was lost
  assign sc_fail = (ent.insn.amo.opcode == `RVFI_OPC_AMO) &&
                   (ent.insn.amo.funct5 == `RVFI_FUNCT5_SC) &&
                   (commit_i.result == `RVFI_XLEN'(1));

  assign is_mret = (ent.insn.raw == `RVFI_INSN_MRET);
  assign is_sret = (ent.insn.raw == `RVFI_INSN_SRET);

  // --------------------
  // Record fields
  // --------------------

  always_comb begin
    trace_d = '0;

    // Only ecalls are reported among the trapping instructions
    trace_d.valid = commit_i.ack && (!commit_i.ex_valid || is_ecall);
    trace_d.insn  = ent.insn.raw;
    trace_d.trap  = exception;
    trace_d.cause = commit_i.ex_cause;
    trace_d.mode  = state_i.debug_mode ? `RVFI_MODE_DEBUG : state_i.priv_lvl;

    trace_d.rs1_addr  = sc_fail ? 5'd0 : commit_i.rs1_addr;
    trace_d.rs2_addr  = sc_fail ? 5'd0 : commit_i.rs2_addr;
    trace_d.rs1_rdata = ent.rs1_rdata;
    trace_d.rs2_rdata = (trace_d.rs2_addr == 5'd0) ? '0 : ent.rs2_rdata;
    trace_d.rd_addr   = commit_i.rd_addr;
    trace_d.rd_wdata  = (commit_i.rd_addr == 5'd0) ? '0 : commit_i.result;  // x0 stays zero

    trace_d.pc_rdata = commit_i.pc;
    if (exception) begin
      trace_d.pc_wdata = {state_i.mtvec[`RVFI_XLEN-1:2], 2'b00};
    end else if (is_mret) begin
      trace_d.pc_wdata = state_i.mepc;
    end else if (is_sret) begin
      trace_d.pc_wdata = state_i.sepc;
    end else if (commit_i.is_ctrl_flow) begin
      trace_d.pc_wdata = commit_i.next_pc;
    end else begin
      trace_d.pc_wdata = commit_i.pc + `RVFI_XLEN'(4);
    end

    // Masks are kept lane-aligned, report them from the access address
    trace_d.mem_addr  = ent.lsu_addr;
    trace_d.mem_rmask = ent.rmask >> ent.lsu_addr[offs_bits-1:0];
    trace_d.mem_wmask = sc_fail ? '0 : (ent.wmask >> ent.lsu_addr[offs_bits-1:0]);
    trace_d.mem_rdata = commit_i.result;
    trace_d.mem_wdata = sc_fail ? '0 : ent.wdata;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_q <= '0;
    end else begin
      trace_q <= trace_d;
    end
  end

  assign trace_o = trace_q;

endmodule

//--- hdl/rvfi_tracer.sv
// --------------------
// Commit trace unit top, taps core pipeline events
// Emits one RVFI record per retired instruction on trace_o
// --------------------
`include "rvfi_settings.svh"

module rvfi_tracer
  import rvfi_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fetch_t      fetch_i,
  input  logic        issue_ack_i,
  input  logic        flush_i,
  input  issue_t      issue_i,
  input  lsu_t        lsu_i,
  input  commit_t     commit_i,
  input  hart_state_t state_i,
  output rvfi_trace_t trace_o
);

  insn_t                               head_insn;  // Instruction being issued
  sb_entry_t [`RVFI_NR_SB_ENTRIES-1:0] entries;

  // --------------------
  // Fetch to issue
  // --------------------

  rvfi_issue_buffer u_issue_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_i     (fetch_i),
    .issue_ack_i (issue_ack_i),
    .flush_i     (flush_i),
    .head_insn_o (head_insn)
  );

  // --------------------
  // Issue and LSU side data
  // --------------------

  rvfi_sb_store u_sb_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue_i),
    .head_insn_i (head_insn),
    .lsu_i       (lsu_i),
    .entries_o   (entries)
  );

  rvfi_commit_pack u_commit_pack (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .commit_i  (commit_i),
    .entries_i (entries),
    .state_i   (state_i),
    .trace_o   (trace_o)
  );

endmodule

//--- test/rvfi_tracer_props.sv
// --------------------
// Trace rule properties, bound into the tracer top
// Failures raise $error and bump a counter read by the testbench
// --------------------
`include "rvfi_settings.svh"

module rvfi_tracer_props
  import rvfi_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input commit_t     commit_i,
  input hart_state_t state_i,
  input rvfi_trace_t trace_i
);

  int unsigned fail_cnt = 0;

  commit_t               cmt_q;    // Commit behind the current record
  hart_state_t           state_q;
  logic                  reportable;
  logic                  sc_failed;
  logic [`RVFI_XLEN-1:0] exp_pc;

  assign reportable = commit_i.ack && (!commit_i.ex_valid || (commit_i.ex_cause inside
                      {`RVFI_CAUSE_ECALL_U, `RVFI_CAUSE_ECALL_S, `RVFI_CAUSE_ECALL_M}));

  // Lost reservation, sc wrote 1 to rd
  assign sc_failed = (trace_i.insn[6:0] == `RVFI_OPC_AMO) &&
                     (trace_i.insn[31:27] == `RVFI_FUNCT5_SC) && (trace_i.mem_rdata == 64'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmt_q   <= '0;
      state_q <= '0;
    end else begin
      cmt_q   <= commit_i;
      state_q <= state_i;
    end
  end

  // --------------------
  // Next pc priority
  // --------------------
  always_comb begin
    if (cmt_q.ex_valid) exp_pc = state_q.mtvec & ~64'h3;
    else if (trace_i.insn == `RVFI_INSN_MRET) exp_pc = state_q.mepc;
    else if (trace_i.insn == `RVFI_INSN_SRET) exp_pc = state_q.sepc;
    else if (cmt_q.is_ctrl_flow) exp_pc = cmt_q.next_pc;
    else exp_pc = cmt_q.pc + 64'd4;
  end

  a_valid_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_i.valid == $past(reportable))
    else begin
      $error("trace valid does not follow the commit by one cycle");
      fail_cnt++;
    end

  a_zero_regs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_i.valid |-> (trace_i.rd_addr != 0 || trace_i.rd_wdata == '0) &&
                      (trace_i.rs2_addr != 0 || trace_i.rs2_rdata == '0))
    else begin
      $error("x0 data is not zero in the trace record");
      fail_cnt++;
    end

  a_pc_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_i.valid |-> trace_i.pc_wdata == exp_pc)
    else begin
      $error("pc_wdata does not follow the next pc priority");
      fail_cnt++;
    end

  a_sc_fail: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_i.valid && sc_failed |-> trace_i.rs1_addr == 0 && trace_i.rs2_addr == 0 &&
                                   trace_i.mem_wmask == '0 && trace_i.mem_wdata == '0)
    else begin
      $error("failed store-conditional still reports operands or a write");
      fail_cnt++;
    end

endmodule

bind rvfi_tracer rvfi_tracer_props u_props (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .commit_i (commit_i),
  .state_i  (state_i),
  .trace_i  (trace_o)
);

//--- test/tb_rvfi_tracer.sv
// --------------------
// Commit tracer testbench driving fetch, issue, LSU and commit events
// Immediate assertions check each record, bound properties check the trace rules
// --------------------
`include "rvfi_settings.svh"

module tb_rvfi_tracer
  import rvfi_pkg::*;
();

  localparam int unsigned n_pairs = 4;
  localparam int unsigned n_ops   = 2 * n_pairs + 11;  // Retired instructions

  logic        clk_i;
  logic        rst_ni;
  fetch_t      fetch;
  logic        issue_ack;
  logic        flush;
  issue_t      issue;
  lsu_t        lsu;
  commit_t     commit;
  hart_state_t state;
  rvfi_trace_t trace;
  logic [31:0] exp_q[$];  // Fetched words, oldest first
  logic [2:0]  ptr;       // Next scoreboard slot

  rvfi_tracer u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_i     (fetch),
    .issue_ack_i (issue_ack),
    .flush_i     (flush),
    .issue_i     (issue),
    .lsu_i       (lsu),
    .commit_i    (commit),
    .state_i     (state),
    .trace_o     (trace)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (n_ops * 20 + 5) @(posedge clk_i);
    $display("Watchdog expired before all instructions retired");
    $display("Test failed");
    $fatal(1);
  end

  always @(negedge clk_i) begin
    if (u_dut.u_props.fail_cnt != 0) begin
      $display("A trace property assertion failed");
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // Compressed words reach issue as their low half
  task automatic fetch_words(input logic [1:0] valid, input logic [1:0] comp,
                             input logic [31:0] w0, input logic [31:0] w1);
    fetch.valid      = valid;
    fetch.compressed = comp;
    fetch.insn       = {w1, w0};
    if (valid[0]) exp_q.push_back(comp[0] ? {16'h0, w0[15:0]} : w0);
    if (valid[1]) exp_q.push_back(comp[1] ? {16'h0, w1[15:0]} : w1);
    @(negedge clk_i);
    fetch = '0;
  endtask

  task automatic issue_next(input logic [63:0] rs1, input logic [63:0] rs2);
    issue     = '{valid: 1'b1, flush_unissued: 1'b0, pointer: ptr, rs1_fwd: rs1, rs2_fwd: rs2};
    issue_ack = 1'b1;
    @(negedge clk_i);
    issue     = '0;
    issue_ack = 1'b0;
    ptr++;
  endtask

  // Report for the most recently issued slot
  task automatic lsu_report(input logic st, input logic [7:0] be, input logic [63:0] addr,
                            input logic [63:0] wdata);
    lsu = '{is_load: !st, is_store: st, be: be, vaddr: addr,
            trans_id: ptr - 3'd1, wdata: wdata};
    @(negedge clk_i);
    lsu = '0;
  endtask

  function automatic commit_t new_commit(input logic [2:0] p, input logic [63:0] result);
    commit_t c;
    c          = '0;
    c.ack      = 1'b1;
    c.pointer  = p;
    c.pc       = rand64() & ~64'h3;
    c.rs1_addr = 5'($urandom_range(1, 31));
    c.rs2_addr = 5'($urandom_range(0, 7));  // Zero now and then
    c.rd_addr  = 5'($urandom_range(0, 7));
    c.result   = result;
    return c;
  endfunction

  // Record is due on the clock after the strobe
  task automatic retire(input string name, input commit_t c, input logic exp_valid);
    logic [31:0] want;
    commit = c;
    @(negedge clk_i);
    commit = '0;
    want   = exp_q.pop_front();
    check_equal({name, " valid"}, exp_valid, trace.valid);
    if (exp_valid) check_equal({name, " insn"}, want, trace.insn);
  endtask

  initial begin
    commit_t     c;
    logic [63:0] rs1, rs2, addr, wd, res;

    void'($urandom(32'hee75_acc2));
    rst_ni    = 1'b0;
    fetch     = '0;
    issue_ack = 1'b0;
    flush     = 1'b0;
    issue     = '0;
    lsu       = '0;
    commit    = '0;
    state     = '{priv_lvl: 2'd3, debug_mode: 1'b0, mtvec: rand64(), mepc: rand64(),
                  sepc: rand64()};
    ptr       = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // --------------------
    // Fetch pairs, retired back to back
    // --------------------
    for (int i = 0; i < n_pairs; i++) begin
      fetch_words(2'b11, 2'($urandom), $urandom, $urandom);
      rs1 = rand64();
      rs2 = rand64();
      issue_next(rs1, rs2);
      issue_next(rand64(), rand64());
      c = new_commit(ptr - 3'd2, rand64());
      retire("pair", c, 1'b1);
      check_equal("pair rs1_rdata", rs1, trace.rs1_rdata);
      check_equal("pair rs2_rdata", (c.rs2_addr == 0) ? 64'h0 : rs2, trace.rs2_rdata);
      check_equal("pair rd_addr", c.rd_addr, trace.rd_addr);
      check_equal("pair rd_wdata", (c.rd_addr == 0) ? 64'h0 : c.result, trace.rd_wdata);
      check_equal("pair pc_rdata", c.pc, trace.pc_rdata);
      check_equal("pair pc_wdata", c.pc + 64'd4, trace.pc_wdata);
      check_equal("pair trap", 1'b0, trace.trap);
      check_equal("pair mode", 2'd3, trace.mode);
      retire("pair", new_commit(ptr - 3'd1, rand64()), 1'b1);
    end

    // --------------------
    // Memory accesses
    // --------------------
    fetch_words(2'b01, 2'b00, 32'h0000_3003, '0);  // ld
    issue_next(rand64(), rand64());
    addr = (rand64() & ~64'h7) | 64'h4;
    lsu_report(1'b0, 8'hf0, addr, '0);
    res = rand64();
    retire("load", new_commit(ptr - 3'd1, res), 1'b1);
    check_equal("load mem_rmask", 8'h0f, trace.mem_rmask);
    check_equal("load mem_addr", addr, trace.mem_addr);
    check_equal("load mem_rdata", res, trace.mem_rdata);

    fetch_words(2'b01, 2'b00, 32'h0000_3023, '0);  // sd
    issue_next(rand64(), rand64());
    addr = (rand64() & ~64'h7) | 64'h2;
    wd   = rand64();
    lsu_report(1'b1, 8'h3c, addr, wd);
    retire("store", new_commit(ptr - 3'd1, '0), 1'b1);
    check_equal("store mem_wmask", 8'h0f, trace.mem_wmask);
    check_equal("store mem_wdata", wd, trace.mem_wdata);

    fetch_words(2'b01, 2'b00, 32'h1005_35af, '0);  // lr.d a1, (a0)
    addr = rand64() & ~64'h7;
    // Report arrives together with the issue of its own slot
    lsu = '{is_load: 1'b0, is_store: 1'b1, be: 8'hff, vaddr: addr, trans_id: ptr,
            wdata: rand64()};
    issue_next(rand64(), rand64());
    lsu = '0;
    retire("lr", new_commit(ptr - 3'd1, rand64()), 1'b1);
    check_equal("lr mem_rmask", 8'hff, trace.mem_rmask);
    check_equal("lr mem_wmask", 8'h00, trace.mem_wmask);

    for (int r = 1; r >= 0; r--) begin
      fetch_words(2'b01, 2'b00, 32'h18b5_362f, '0);  // sc.d a2, a1, (a0)
      issue_next(rand64(), rand64());
      wd = rand64();
      lsu_report(1'b1, 8'hff, addr, wd);
      c = new_commit(ptr - 3'd1, 64'(r));
      retire("sc", c, 1'b1);
      check_equal("sc rs1_addr", r ? 5'd0 : c.rs1_addr, trace.rs1_addr);
      check_equal("sc rs2_addr", r ? 5'd0 : c.rs2_addr, trace.rs2_addr);
      check_equal("sc mem_wmask", r ? 8'h00 : 8'hff, trace.mem_wmask);
      check_equal("sc mem_wdata", r ? 64'h0 : wd, trace.mem_wdata);
    end

    // --------------------
    // Traps and next pc
    // --------------------
    fetch_words(2'b01, 2'b00, 32'h0000_0073, '0);  // ecall
    issue_next(rand64(), rand64());
    c          = new_commit(ptr - 3'd1, '0);
    c.ex_valid = 1'b1;
    c.ex_cause = 64'd11;
    retire("ecall", c, 1'b1);
    check_equal("ecall trap", 1'b1, trace.trap);
    check_equal("ecall cause", 64'd11, trace.cause);
    check_equal("ecall pc_wdata", state.mtvec & ~64'h3, trace.pc_wdata);

    fetch_words(2'b01, 2'b00, 32'h0000_0000, '0);  // Illegal word
    issue_next(rand64(), rand64());
    c          = new_commit(ptr - 3'd1, '0);
    c.ex_valid = 1'b1;
    c.ex_cause = 64'd2;
    retire("illegal", c, 1'b0);

    fetch_words(2'b01, 2'b00, `RVFI_INSN_MRET, '0);
    issue_next(rand64(), rand64());
    retire("mret", new_commit(ptr - 3'd1, '0), 1'b1);
    check_equal("mret pc_wdata", state.mepc, trace.pc_wdata);

    fetch_words(2'b01, 2'b00, `RVFI_INSN_SRET, '0);
    issue_next(rand64(), rand64());
    retire("sret", new_commit(ptr - 3'd1, '0), 1'b1);
    check_equal("sret pc_wdata", state.sepc, trace.pc_wdata);

    state.debug_mode = 1'b1;
    fetch_words(2'b01, 2'b00, 32'h0000_006f, '0);  // jal x0
    issue_next(rand64(), rand64());
    c              = new_commit(ptr - 3'd1, rand64());
    c.rd_addr      = 5'd0;  // Link value is dropped
    c.rs2_addr     = 5'd0;
    c.is_ctrl_flow = 1'b1;
    c.next_pc      = rand64();
    retire("jump", c, 1'b1);
    check_equal("jump pc_wdata", c.next_pc, trace.pc_wdata);
    check_equal("jump rd_wdata", 64'h0, trace.rd_wdata);
    check_equal("jump rs2_rdata", 64'h0, trace.rs2_rdata);
    check_equal("debug mode", 2'd2, trace.mode);
    state.debug_mode = 1'b0;

    // Buffered words vanish with the flush
    fetch_words(2'b11, 2'b00, $urandom, $urandom);
    flush = 1'b1;
    exp_q.delete();
    @(negedge clk_i);
    flush = 1'b0;
    fetch_words(2'b01, 2'b01, $urandom, '0);
    issue_next(rand64(), rand64());
    retire("flush", new_commit(ptr - 3'd1, '0), 1'b1);

    @(negedge clk_i);
    if (u_dut.u_props.fail_cnt != 0) begin
      $display("A trace property assertion failed");
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- src.f
+incdir+hdl
hdl/rvfi_pkg.sv
hdl/rvfi_issue_buffer.sv
hdl/rvfi_sb_store.sv
hdl/rvfi_commit_pack.sv
hdl/rvfi_tracer.sv
test/rvfi_tracer_props.sv
test/tb_rvfi_tracer.sv

//--- Bender.yml
package:
  name: rvfi_tracer

export_include_dirs:
  - hdl

sources:
  - hdl/rvfi_pkg.sv
  - hdl/rvfi_issue_buffer.sv
  - hdl/rvfi_sb_store.sv
  - hdl/rvfi_commit_pack.sv
  - hdl/rvfi_tracer.sv
  - target: test
    files:
      - test/rvfi_tracer_props.sv
      - test/tb_rvfi_tracer.sv
